//--- dircc_types_pkg.sv
`default_nettype none

package dircc_types_pkg;

  // two-state flag used inside the design
  typedef enum logic {
    FALSE = 1'b0,
    TRUE  = 1'b1
  } bool;

  // node address as carried in two beats of a frame
  typedef struct packed {
    logic [31:0] hw_addr;
    logic [15:0] sw_addr;
    logic [6:0]  port;
    logic        flag;
  } node_addr_t;

  // one reassembled message, 240 bits
  typedef struct packed {
    node_addr_t  dest_addr;
    node_addr_t  src_addr;
    logic [31:0] lamport;      // sender logical clock
    logic [95:0] data;         // word 0 in the low bits
  } packet_t;

endpackage : dircc_types_pkg

`default_nettype wire

//--- dircc_stream_pkg.sv
`default_nettype none

package dircc_stream_pkg;

  localparam int BEAT_WIDTH = 32;

  // one stream beat with its framing marks
  typedef struct packed {
    logic [BEAT_WIDTH-1:0] data;
    logic                  sop;
    logic                  eop;
  } beat_t;

  localparam int BEATS_PER_PACKET   = 8;
  localparam int BEAT_FIFO_DEPTH    = 8;
  localparam int PACKET_QUEUE_DEPTH = 4;

  localparam int CFG_ADDR_WIDTH = 3;

  // register map
  localparam logic [CFG_ADDR_WIDTH-1:0] REG_CTRL      = 3'd0;  // bit 0 filter enable
  localparam logic [CFG_ADDR_WIDTH-1:0] REG_LOCAL_HW  = 3'd1;
  localparam logic [CFG_ADDR_WIDTH-1:0] REG_ACCEPTED  = 3'd2;
  localparam logic [CFG_ADDR_WIDTH-1:0] REG_DROPPED   = 3'd3;
  localparam logic [CFG_ADDR_WIDTH-1:0] REG_FRAME_ERR = 3'd4;

endpackage : dircc_stream_pkg

`default_nettype wire

//--- dircc_st_if.sv
`timescale 1ns/1ps
`default_nettype none

interface dircc_st_if #(
  parameter int WIDTH = 32
);

  logic [WIDTH-1:0] data;
  logic             sop;
  logic             eop;
  logic             valid;
  logic             ready;   // driven by the sink

  // source holds data, sop, eop and valid until valid && ready
  modport source (output data, output sop, output eop, output valid, input ready);

  modport sink (input data, input sop, input eop, input valid, output ready);

endinterface : dircc_st_if

`default_nettype wire

//--- dircc_sync_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module dircc_sync_fifo #(
  parameter type item_t = logic,
  parameter int  DEPTH  = 4
) (
  input  logic  clk,
  input  logic  reset_n,

  input  item_t in_item,
  input  logic  in_valid,
  output logic  in_ready,

  output item_t out_item,
  output logic  out_valid,
  input  logic  out_ready
);

  import dircc_types_pkg::*;

  typedef logic [$clog2(DEPTH)-1:0]   ptr_t;
  typedef logic [$clog2(DEPTH+1)-1:0] count_t;

  item_t  mem [DEPTH];
  ptr_t   wr_ptr;
  ptr_t   rd_ptr;
  count_t count;
  count_t count_n;
  bool    do_push;
  bool    do_pop;

  function automatic ptr_t ptr_inc(input ptr_t p);
    return (p == ptr_t'(DEPTH - 1)) ? '0 : p + 1'b1;  // wrap for any depth
  endfunction

  assign do_push = bool'(in_valid && in_ready);
  assign do_pop  = bool'(out_valid && out_ready);

  // show-ahead, head is always on the output
  assign out_item  = mem[rd_ptr];
  assign out_valid = (count != '0);

  always_comb begin
    count_n = count;
    if (do_push == TRUE && do_pop == FALSE) begin
      count_n = count + 1'b1;
    end else if (do_push == FALSE && do_pop == TRUE) begin
      count_n = count - 1'b1;
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      in_ready <= 1'b0;  // held off until out of reset
    end else begin
      if (do_push == TRUE) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (do_pop == TRUE) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      count    <= count_n;
      in_ready <= (count_n != count_t'(DEPTH));  // low only when full
    end
  end

  always_ff @(posedge clk) begin
    if (do_push == TRUE) begin
      mem[wr_ptr] <= in_item;
    end
  end

endmodule : dircc_sync_fifo

`default_nettype wire

//--- dircc_packet_receiver.sv
`timescale 1ns/1ps
`default_nettype none

module dircc_packet_receiver (
  input  logic                     clk,
  input  logic                     reset_n,

  dircc_st_if.sink                 st,

  input  logic                     filter_enable,
  input  logic [31:0]              local_hw_addr,

  output dircc_types_pkg::packet_t push_packet,
  output logic                     push_valid,
  input  logic                     push_ready,

  output logic                     pkt_accepted,
  output logic                     pkt_dropped,
  output logic                     frame_error
);

  import dircc_types_pkg::*;
  import dircc_stream_pkg::*;

  typedef logic [$clog2(BEATS_PER_PACKET)-1:0] beat_idx_t;

  typedef enum logic [1:0] {
    S_COLLECT,    // building a frame
    S_HUNT_SOP,   // dropping beats until sop
    S_HUNT_EOP,   // dropping beats through eop
    S_DELIVER     // complete frame waiting on the queue
  } rx_state_t;

  rx_state_t state;
  beat_idx_t beat_cnt;
  packet_t   asm_pkt;
  logic      rx_ready;
  logic      take_beat;
  logic      last_beat;
  bool       addr_match;

  assign st.ready  = rx_ready;
  assign take_beat = st.valid && rx_ready;
  assign last_beat = (beat_cnt == beat_idx_t'(BEATS_PER_PACKET - 1));

  assign addr_match = bool'(!filter_enable || asm_pkt.dest_addr.hw_addr == local_hw_addr);

  assign push_packet = asm_pkt;
  assign push_valid  = (state == S_DELIVER) && (addr_match == TRUE) && push_ready;

  // fields land in frame order, no reset on the payload
  always_ff @(posedge clk) begin
    if (take_beat && (state == S_COLLECT || state == S_HUNT_SOP)) begin
      case (beat_cnt)
        3'd0: asm_pkt.dest_addr.hw_addr <= st.data;
        3'd1: begin
          {asm_pkt.dest_addr.sw_addr, asm_pkt.dest_addr.port,
           asm_pkt.dest_addr.flag} <= st.data[31:8];
        end
        3'd2: asm_pkt.src_addr.hw_addr <= st.data;
        3'd3: begin
          {asm_pkt.src_addr.sw_addr, asm_pkt.src_addr.port,
           asm_pkt.src_addr.flag} <= st.data[31:8];
        end
        3'd4: asm_pkt.lamport <= st.data;
        3'd5: asm_pkt.data[31:0] <= st.data;
        3'd6: asm_pkt.data[63:32] <= st.data;
        default: asm_pkt.data[95:64] <= st.data;
      endcase
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state        <= S_COLLECT;
      beat_cnt     <= '0;
      rx_ready     <= 1'b0;
      pkt_accepted <= 1'b0;
      pkt_dropped  <= 1'b0;
      frame_error  <= 1'b0;
    end else begin
      pkt_accepted <= 1'b0;
      pkt_dropped  <= 1'b0;
      frame_error  <= 1'b0;
      rx_ready     <= 1'b1;
      case (state)
        S_COLLECT, S_HUNT_SOP: begin
          if (take_beat) begin
            if (beat_cnt == '0 && !st.sop) begin
              frame_error <= (state == S_COLLECT);  // counted once per hunt
              state       <= S_HUNT_SOP;
            end else if (st.eop && !last_beat) begin
              frame_error <= 1'b1;  // short frame
              beat_cnt    <= '0;
              state       <= S_COLLECT;
            end else if (last_beat) begin
              beat_cnt <= '0;
              if (st.eop) begin
                state    <= S_DELIVER;
                rx_ready <= 1'b0;
              end else begin
                frame_error <= 1'b1;  // long frame
                state       <= S_HUNT_EOP;
              end
            end else begin
              beat_cnt <= beat_cnt + 1'b1;
              state    <= S_COLLECT;
            end
          end
        end
        S_HUNT_EOP: begin
          if (take_beat && st.eop) begin
            state <= S_COLLECT;
          end
        end
        S_DELIVER: begin
          if (addr_match == FALSE) begin
            pkt_dropped <= 1'b1;
            state       <= S_COLLECT;
          end else if (push_ready) begin
            pkt_accepted <= 1'b1;
            state        <= S_COLLECT;
          end else begin
            rx_ready <= 1'b0;  // queue full, stall the stream
          end
        end
        default: state <= S_COLLECT;
      endcase
    end
  end

endmodule : dircc_packet_receiver

`default_nettype wire

//--- dircc_rx_regs.sv
`timescale 1ns/1ps
`default_nettype none

module dircc_rx_regs (
  input  logic                                      clk,
  input  logic                                      reset_n,

  input  logic                                      cfg_write,
  input  logic [dircc_stream_pkg::CFG_ADDR_WIDTH-1:0] cfg_addr,
  input  logic [31:0]                               cfg_wdata,
  output logic [31:0]                               cfg_rdata,

  output logic                                      filter_enable,
  output logic [31:0]                               local_hw_addr,

  input  logic                                      pkt_accepted,
  input  logic                                      pkt_dropped,
  input  logic                                      frame_error
);

  import dircc_stream_pkg::*;

  logic [31:0] accepted_cnt;
  logic [31:0] dropped_cnt;
  logic [31:0] frame_err_cnt;
  logic        clr_accepted;
  logic        clr_dropped;
  logic        clr_frame_err;

  // saturating count, a clear with a same-edge event leaves 1
  function automatic logic [31:0] next_count(input logic [31:0] cnt,
                                             input logic        clr,
                                             input logic        evt);
    logic [31:0] nxt;
    if (clr) begin
      nxt = {31'd0, evt};
    end else if (evt && cnt != '1) begin
      nxt = cnt + 1'b1;
    end else begin
      nxt = cnt;
    end
    return nxt;
  endfunction

  assign clr_accepted  = cfg_write && (cfg_addr == REG_ACCEPTED);
  assign clr_dropped   = cfg_write && (cfg_addr == REG_DROPPED);
  assign clr_frame_err = cfg_write && (cfg_addr == REG_FRAME_ERR);

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      filter_enable <= 1'b0;
      local_hw_addr <= '0;
      accepted_cnt  <= '0;
      dropped_cnt   <= '0;
      frame_err_cnt <= '0;
    end else begin
      if (cfg_write && cfg_addr == REG_CTRL) begin
        filter_enable <= cfg_wdata[0];
      end
      if (cfg_write && cfg_addr == REG_LOCAL_HW) begin
        local_hw_addr <= cfg_wdata;
      end
      accepted_cnt  <= next_count(accepted_cnt, clr_accepted, pkt_accepted);
      dropped_cnt   <= next_count(dropped_cnt, clr_dropped, pkt_dropped);
      frame_err_cnt <= next_count(frame_err_cnt, clr_frame_err, frame_error);
    end
  end

  always_comb begin
    case (cfg_addr)
      REG_CTRL:      cfg_rdata = {31'd0, filter_enable};
      REG_LOCAL_HW:  cfg_rdata = local_hw_addr;
      REG_ACCEPTED:  cfg_rdata = accepted_cnt;
      REG_DROPPED:   cfg_rdata = dropped_cnt;
      REG_FRAME_ERR: cfg_rdata = frame_err_cnt;
      default:       cfg_rdata = '0;  // unmapped
    endcase
  end

endmodule : dircc_rx_regs

`default_nettype wire

//--- dircc_rx_top.sv
`timescale 1ns/1ps
`default_nettype none

module dircc_rx_top (
  input  logic                                        clk,
  input  logic                                        reset_n,

  input  logic [dircc_stream_pkg::BEAT_WIDTH-1:0]     in_data,
  input  logic                                        in_sop,
  input  logic                                        in_eop,
  input  logic                                        in_valid,
  output logic                                        in_ready,

  input  logic                                        read_packet,
  output logic                                        packet_valid,
  output dircc_types_pkg::packet_t                    packet_data,

  input  logic                                        cfg_write,
  input  logic [dircc_stream_pkg::CFG_ADDR_WIDTH-1:0] cfg_addr,
  input  logic [31:0]                                 cfg_wdata,
  output logic [31:0]                                 cfg_rdata
);

  import dircc_types_pkg::*;
  import dircc_stream_pkg::*;

  beat_t       in_beat;
  beat_t       fifo_beat;
  packet_t     rx_packet;
  logic        rx_push_valid;
  logic        rx_push_ready;
  logic        filter_enable;
  logic [31:0] local_hw_addr;
  logic        pkt_accepted;
  logic        pkt_dropped;
  logic        frame_error;

  dircc_st_if #(.WIDTH(BEAT_WIDTH)) st_beats ();

  assign in_beat = '{data: in_data, sop: in_sop, eop: in_eop};

  // fifo head onto the stream interface
  assign st_beats.data = fifo_beat.data;
  assign st_beats.sop  = fifo_beat.sop;
  assign st_beats.eop  = fifo_beat.eop;

  dircc_sync_fifo #(
    .item_t (beat_t),
    .DEPTH  (BEAT_FIFO_DEPTH)
  ) beat_fifo (
    .clk       (clk),
    .reset_n   (reset_n),
    .in_item   (in_beat),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_item  (fifo_beat),
    .out_valid (st_beats.valid),
    .out_ready (st_beats.ready)
  );

  dircc_packet_receiver receiver (
    .clk           (clk),
    .reset_n       (reset_n),
    .st            (st_beats.sink),
    .filter_enable (filter_enable),
    .local_hw_addr (local_hw_addr),
    .push_packet   (rx_packet),
    .push_valid    (rx_push_valid),
    .push_ready    (rx_push_ready),
    .pkt_accepted  (pkt_accepted),
    .pkt_dropped   (pkt_dropped),
    .frame_error   (frame_error)
  );

  dircc_sync_fifo #(
    .item_t (packet_t),
    .DEPTH  (PACKET_QUEUE_DEPTH)
  ) packet_queue (
    .clk       (clk),
    .reset_n   (reset_n),
    .in_item   (rx_packet),
    .in_valid  (rx_push_valid),
    .in_ready  (rx_push_ready),
    .out_item  (packet_data),
    .out_valid (packet_valid),
    .out_ready (read_packet)   // pop ignored when empty
  );

  dircc_rx_regs rx_regs (
    .clk           (clk),
    .reset_n       (reset_n),
    .cfg_write     (cfg_write),
    .cfg_addr      (cfg_addr),
    .cfg_wdata     (cfg_wdata),
    .cfg_rdata     (cfg_rdata),
    .filter_enable (filter_enable),
    .local_hw_addr (local_hw_addr),
    .pkt_accepted  (pkt_accepted),
    .pkt_dropped   (pkt_dropped),
    .frame_error   (frame_error)
  );

endmodule : dircc_rx_top

`default_nettype wire

//--- tb_dircc_rx.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dircc_rx;

  import dircc_types_pkg::*;
  import dircc_stream_pkg::*;

  typedef enum int {CORR_NONE, CORR_NO_SOP, CORR_SHORT, CORR_LONG} corrupt_e;
  typedef enum int {RES_ACCEPT, RES_DROP, RES_FRAME_ERR} result_e;

  // beats over all tests: 1, 8, 10 good frames, test 4 mix, 40 random
  localparam int TOTAL_BEATS     = 8 + 64 + 80 + 55 + 320;
  localparam int WATCHDOG_CYCLES = TOTAL_BEATS * 40 + 2000;
  localparam int POLL_LIMIT      = 1000;

  logic                      clk;
  logic                      reset_n;
  logic [BEAT_WIDTH-1:0]     in_data;
  logic                      in_sop;
  logic                      in_eop;
  logic                      in_valid;
  logic                      in_ready;
  logic                      read_packet;
  logic                      packet_valid;
  packet_t                   packet_data;
  logic                      cfg_write;
  logic [CFG_ADDR_WIDTH-1:0] cfg_addr;
  logic [31:0]               cfg_wdata;
  logic [31:0]               cfg_rdata;

  packet_t     exp_q[$];     // accepted packets in send order
  int          exp_accepted;
  int          exp_dropped;
  int          exp_frame_err;
  logic        filt_en;      // model of the filter registers
  logic [31:0] filt_hw;
  logic [31:0] stim_rng;
  logic [31:0] read_rng;
  int          max_read_delay;
  bool         reads_paused;
  bool         stall_seen;
  bool         burst_done;
  string       test_name;
  int          checks;
  int          errors;

  dircc_rx_top dut (
    .clk          (clk),
    .reset_n      (reset_n),
    .in_data      (in_data),
    .in_sop       (in_sop),
    .in_eop       (in_eop),
    .in_valid     (in_valid),
    .in_ready     (in_ready),
    .read_packet  (read_packet),
    .packet_valid (packet_valid),
    .packet_data  (packet_data),
    .cfg_write    (cfg_write),
    .cfg_addr     (cfg_addr),
    .cfg_wdata    (cfg_wdata),
    .cfg_rdata    (cfg_rdata)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] rand32();
    stim_rng = xorshift32(stim_rng);
    return stim_rng;
  endfunction

  function automatic packet_t make_packet(input logic [31:0] dest_hw);
    packet_t     p;
    logic [31:0] r;
    p.dest_addr.hw_addr = dest_hw;
    r = rand32();
    p.dest_addr.sw_addr = r[15:0];
    p.dest_addr.port    = r[22:16];
    p.dest_addr.flag    = r[23];
    p.src_addr.hw_addr  = rand32();
    r = rand32();
    p.src_addr.sw_addr  = r[15:0];
    p.src_addr.port     = r[22:16];
    p.src_addr.flag     = r[23];
    p.lamport           = rand32();
    p.data              = {rand32(), rand32(), rand32()};
    return p;
  endfunction

  function automatic logic [31:0] other_addr(input logic [31:0] local_hw);
    logic [31:0] r;
    r = rand32();
    return (r == local_hw) ? ~r : r;
  endfunction

  // what the receiver should do with one frame
  function automatic result_e expect_result(input packet_t p, input corrupt_e kind,
                                            input logic filter_on, input logic [31:0] local_hw);
    if (kind != CORR_NONE) begin
      return RES_FRAME_ERR;
    end
    if (!filter_on || p.dest_addr.hw_addr == local_hw) begin
      return RES_ACCEPT;
    end
    return RES_DROP;
  endfunction

  task automatic check_value(input string what, input logic [255:0] expected,
                             input logic [255:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("ERROR %s %s: expected %0h actual %0h", test_name, what, expected, actual);
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #2;
    end
  endtask

  // called 2 ns after an edge, returns 2 ns after the accepting edge
  task automatic drive_beat(input logic [31:0] d, input logic s, input logic e);
    bit taken;
    taken    = 1'b0;
    in_data  = d;
    in_sop   = s;
    in_eop   = e;
    in_valid = 1'b1;
    while (!taken) begin
      @(negedge clk);
      if (in_ready) taken = 1'b1;
      else stall_seen = TRUE;
      @(posedge clk);
      #2;
    end
    in_valid = 1'b0;
  endtask

  task automatic send_frame(input packet_t p, input corrupt_e kind, input int max_gap);
    logic [31:0] words [8];
    int          n_beats;
    int          i;
    case (expect_result(p, kind, filt_en, filt_hw))
      RES_ACCEPT: begin
        exp_q.push_back(p);
        exp_accepted++;
      end
      RES_DROP:   exp_dropped++;
      default:    exp_frame_err++;
    endcase
    words[0] = p.dest_addr.hw_addr;
    words[1] = {p.dest_addr.sw_addr, p.dest_addr.port, p.dest_addr.flag, 8'h00};
    words[2] = p.src_addr.hw_addr;
    words[3] = {p.src_addr.sw_addr, p.src_addr.port, p.src_addr.flag, 8'h00};
    words[4] = p.lamport;
    words[5] = p.data[31:0];
    words[6] = p.data[63:32];
    words[7] = p.data[95:64];
    n_beats = (kind == CORR_SHORT) ? 5 : BEATS_PER_PACKET;
    for (i = 0; i < n_beats; i++) begin
      if (max_gap > 0) idle_cycles(rand32() % (max_gap + 1));
      drive_beat(words[i], (i == 0) && (kind != CORR_NO_SOP),
                 (i == n_beats - 1) && (kind != CORR_LONG));
    end
    if (kind == CORR_LONG) begin  // trailing junk up to an eop
      drive_beat(rand32(), 1'b0, 1'b0);
      drive_beat(rand32(), 1'b0, 1'b1);
    end
  endtask

  task automatic write_reg(input logic [CFG_ADDR_WIDTH-1:0] addr, input logic [31:0] data);
    cfg_write = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    @(posedge clk);
    #2;
    cfg_write = 1'b0;
    case (addr)
      REG_CTRL:      filt_en = data[0];
      REG_LOCAL_HW:  filt_hw = data;
      REG_ACCEPTED:  exp_accepted = 0;
      REG_DROPPED:   exp_dropped = 0;
      REG_FRAME_ERR: exp_frame_err = 0;
      default:       ;
    endcase
  endtask

  task automatic read_reg(input logic [CFG_ADDR_WIDTH-1:0] addr, output logic [31:0] data);
    cfg_addr = addr;
    @(negedge clk);
    data = cfg_rdata;
    @(posedge clk);
    #2;
  endtask

  // the counters summing to the expected events marks the receiver as done
  task automatic wait_events();
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] f;
    int          polls;
    bit          done;
    polls = 0;
    done  = 1'b0;
    while (!done && polls < POLL_LIMIT) begin
      read_reg(REG_ACCEPTED, a);
      read_reg(REG_DROPPED, d);
      read_reg(REG_FRAME_ERR, f);
      done = (a + d + f) >= (exp_accepted + exp_dropped + exp_frame_err);
      polls++;
    end
    if (!done) begin
      errors++;
      $display("%s: receiver events never reached the expected total", test_name);
    end
    polls = 0;
    while (exp_q.size() != 0 && polls < POLL_LIMIT) begin
      idle_cycles(1);
      polls++;
    end
    if (exp_q.size() != 0) begin
      errors++;
      $display("%s: expected packets never arrived", test_name);
    end
  endtask

  task automatic check_counters();
    logic [31:0] v;
    read_reg(REG_ACCEPTED, v);
    check_value("accepted count", exp_accepted, v);
    read_reg(REG_DROPPED, v);
    check_value("dropped count", exp_dropped, v);
    read_reg(REG_FRAME_ERR, v);
    check_value("frame error count", exp_frame_err, v);
  endtask

  // host side, pops and compares against the expected queue
  initial begin : compare_proc
    int      wait_left;
    packet_t head;
    wait_left   = 0;
    read_packet = 1'b0;
    @(posedge reset_n);
    forever begin
      @(posedge clk);
      #2;
      read_packet = 1'b0;
      if (reads_paused == FALSE && packet_valid) begin
        if (wait_left > 0) begin
          wait_left--;
        end else begin
          if (exp_q.size() == 0) begin
            errors++;
            $display("%s: packet_valid with empty expected queue", test_name);
          end else begin
            head = exp_q.pop_front();
            check_value("packet", head, packet_data);
          end
          read_packet = 1'b1;
          read_rng    = xorshift32(read_rng);
          wait_left   = (max_read_delay > 0) ? read_rng % (max_read_delay + 1) : 0;
        end
      end
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired in %s, errors: %0d", test_name, errors);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin : main_seq
    int          i;
    logic [31:0] v;
    logic [31:0] dest;
    reset_n   = 1'b0;
    in_data   = '0;
    in_sop    = 1'b0;
    in_eop    = 1'b0;
    in_valid  = 1'b0;
    cfg_write = 1'b0;
    cfg_addr  = '0;
    cfg_wdata = '0;
    exp_accepted   = 0;
    exp_dropped    = 0;
    exp_frame_err  = 0;
    filt_en        = 1'b0;  // registers clear on reset
    filt_hw        = '0;
    stim_rng       = 32'hee3a;
    read_rng       = 32'hee3a;
    max_read_delay = 0;
    reads_paused   = FALSE;
    stall_seen     = FALSE;
    burst_done     = FALSE;
    checks         = 0;
    errors         = 0;
    test_name      = "reset";
    repeat (2) @(posedge clk);
    #2;
    reset_n = 1'b1;
    idle_cycles(1);

    test_name = "single";
    send_frame(make_packet(rand32()), CORR_NONE, 0);
    wait_events();
    check_counters();

    test_name = "filter";
    write_reg(REG_LOCAL_HW, 32'h0000_c0de);
    write_reg(REG_CTRL, 32'd1);
    for (i = 0; i < 8; i++) begin
      dest = (i % 3 == 2) ? other_addr(filt_hw) : filt_hw;
      send_frame(make_packet(dest), CORR_NONE, 0);
    end
    wait_events();
    check_counters();

    test_name = "backpressure";
    write_reg(REG_CTRL, 32'd0);
    stall_seen   = FALSE;
    reads_paused = TRUE;
    fork
      begin
        for (i = 0; i < 10; i++) send_frame(make_packet(rand32()), CORR_NONE, 0);
        burst_done = TRUE;
      end
      begin
        wait (stall_seen == TRUE || burst_done == TRUE);
        repeat (16) @(posedge clk);
        reads_paused = FALSE;
      end
    join
    check_value("sender stalled", 1'b1, stall_seen == TRUE);
    wait_events();
    check_counters();

    test_name = "framing";
    send_frame(make_packet(rand32()), CORR_NONE, 0);
    send_frame(make_packet(rand32()), CORR_NO_SOP, 0);
    send_frame(make_packet(rand32()), CORR_NONE, 0);
    send_frame(make_packet(rand32()), CORR_SHORT, 0);
    send_frame(make_packet(rand32()), CORR_NONE, 0);
    send_frame(make_packet(rand32()), CORR_LONG, 0);
    send_frame(make_packet(rand32()), CORR_NONE, 0);
    wait_events();
    check_counters();

    test_name = "registers";
    write_reg(REG_CTRL, 32'd1);
    read_reg(REG_CTRL, v);
    check_value("ctrl", 32'd1, v);
    write_reg(REG_LOCAL_HW, 32'ha5a5_0f0f);
    read_reg(REG_LOCAL_HW, v);
    check_value("local hw", 32'ha5a5_0f0f, v);
    for (i = 5; i < 8; i++) begin
      read_reg(CFG_ADDR_WIDTH'(i), v);
      check_value($sformatf("unmapped %0d", i), 32'd0, v);
    end
    write_reg(REG_ACCEPTED, 32'd0);
    write_reg(REG_DROPPED, 32'd0);
    write_reg(REG_FRAME_ERR, 32'd0);
    check_counters();

    test_name = "random";
    write_reg(REG_LOCAL_HW, 32'h1234_5678);
    write_reg(REG_CTRL, 32'd1);
    max_read_delay = 3;
    for (i = 0; i < 40; i++) begin
      dest = rand32();
      dest = dest[0] ? filt_hw : other_addr(filt_hw);
      send_frame(make_packet(dest), CORR_NONE, 2);
    end
    wait_events();
    check_counters();
    idle_cycles(2);  // last pop lands
    check_value("queue empty", 1'b0, packet_valid);

    $display("checks: %0d errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule : tb_dircc_rx

`default_nettype wire

//--- sim.f
dircc_types_pkg.sv
dircc_stream_pkg.sv
dircc_st_if.sv
dircc_sync_fifo.sv
dircc_packet_receiver.sv
dircc_rx_regs.sv
dircc_rx_top.sv
tb_dircc_rx.sv
